// File: Makefile
TOP = tb_lb_marble_slave

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module $(TOP) --Mdir obj_dir -o sim_bin
	./obj_dir/sim_bin | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// File: hw/control_bank.sv
// Direct control registers and 32-word mirror; every region-0x05 write also lands in the mirror
`include "marble_cfg.svh"

module control_bank (
	input  logic clk,
	input  logic rst_n,
	lb_if.bank_rw bus,
	output lb_pkg::lb_word_t ctrl_word,
	output lb_pkg::lb_word_t mirror_word,
	output logic rx_mac_hbank,
	output marble_regs_pkg::misc_config_t misc_config,
	output logic [1:0] led_user_mode,
	output logic led1,
	output logic led2
);

	logic do_rd;
	logic mem_we;
	logic [1:0] led_user_r;
	logic [7:0] led1_df;
	logic [7:0] led2_df;
	logic rx_hbank_r;
	marble_regs_pkg::misc_config_t misc_config_r;
	lb_pkg::lb_word_t mirror_mem [0:2**`MIRROR_AW-1];

	assign do_rd = bus.strobe & bus.rd;
	// Writes into region 0x05, any offset
	assign mem_we = bus.strobe & ~bus.rd &
		(bus.addr[`LB_AW-1 -: 8] == lb_pkg::REGION_MIRROR);

	// ------------------------------------------------------------
	// Direct writes
	// ------------------------------------------------------------
	// Only the low bits of the write word are kept
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			led_user_r <= 2'b00;
			led1_df <= 8'h00;
			led2_df <= 8'h00;
			rx_hbank_r <= `RX_HBANK_DEFAULT;
			misc_config_r <= marble_regs_pkg::misc_config_t'(`MISC_CONFIG_DEFAULT);
		end else if (mem_we) begin
			case (marble_regs_pkg::ctrl_idx_e'(bus.addr[4:0]))
				marble_regs_pkg::LED_USER:    led_user_r <= bus.wdata[1:0];
				marble_regs_pkg::LED1_DF:     led1_df <= bus.wdata[7:0];
				marble_regs_pkg::LED2_DF:     led2_df <= bus.wdata[7:0];
				marble_regs_pkg::RX_HBANK:    rx_hbank_r <= bus.wdata[0];
				marble_regs_pkg::MISC_CONFIG:
					misc_config_r <= marble_regs_pkg::misc_config_t'(bus.wdata[7:0]);
				default: ;
			endcase
		end
	end

	// ------------------------------------------------------------
	// Mirror memory and first read stage
	// ------------------------------------------------------------
	// Addresses alias modulo the mirror depth
	always_ff @(posedge clk) begin
		if (mem_we)
			mirror_mem[bus.addr[`MIRROR_AW-1:0]] <= bus.wdata;
	end

	always_ff @(posedge clk) begin
		if (do_rd)
			mirror_word <= mirror_mem[bus.addr[`MIRROR_AW-1:0]];
	end

	// Readback of the registers, slot from addr[3:0]
	always_ff @(posedge clk) begin
		if (do_rd) begin
			case (marble_regs_pkg::ctrl_idx_e'({1'b0, bus.addr[3:0]}))
				marble_regs_pkg::LED_USER:    ctrl_word <= lb_pkg::lb_word_t'(led_user_r);
				marble_regs_pkg::LED1_DF:     ctrl_word <= lb_pkg::lb_word_t'(led1_df);
				marble_regs_pkg::LED2_DF:     ctrl_word <= lb_pkg::lb_word_t'(led2_df);
				marble_regs_pkg::RX_HBANK:    ctrl_word <= lb_pkg::lb_word_t'(rx_hbank_r);
				marble_regs_pkg::MISC_CONFIG: ctrl_word <= lb_pkg::lb_word_t'(misc_config_r);
				default:                      ctrl_word <= '0;
			endcase
		end
	end

	// LED dimming
	led_pwm u_led_pwm (
		.clk     (clk),
		.rst_n   (rst_n),
		.led1_df (led1_df),
		.led2_df (led2_df),
		.led1    (led1),
		.led2    (led2)
	);

	assign led_user_mode = led_user_r;
	assign rx_mac_hbank = rx_hbank_r;
	assign misc_config = misc_config_r;

	// A read never stores into the mirror
	a_no_write_on_read: assert property (@(posedge clk) disable iff (!rst_n)
		mem_we |-> !bus.rd)
		else $error("mirror write during a read request");

endmodule

// File: hw/lb_if.sv
// Request side of the local bus; single-cycle requests only, no back-pressure
interface lb_if;

	// Driven by the top level from its plain ports
	lb_pkg::lb_addr_t addr;
	logic strobe;
	// High for a read, low for a write
	logic rd;
	lb_pkg::lb_word_t wdata;

	// ------------------------------------------------------------
	// Bank views
	// ------------------------------------------------------------
	// Read-only bank sees no write data
	modport bank_rd (
		input addr,
		input strobe,
		input rd
	);

	// Writable bank
	modport bank_rw (
		input addr,
		input strobe,
		input rd,
		input wdata
	);

endinterface

// File: hw/lb_marble_slave.sv
// Local-bus slave top; fixed two-cycle read latency, no back-pressure, one request per cycle
module lb_marble_slave (
	input  logic clk,
	input  logic rst_n,
	// Local bus
	input  lb_pkg::lb_addr_t addr,
	input  logic control_strobe,
	input  logic control_rd,
	input  lb_pkg::lb_word_t data_out,
	output lb_pkg::lb_word_t data_in,
	output logic data_valid,
	// Status inputs, already in the clk domain
	input  logic xdomain_fault,
	input  logic tx_mac_done,
	input  logic [1:0] rx_mac_buf_status,
	// Board controls
	output logic rx_mac_hbank,
	output logic cfg_d02,
	output logic mmc_int,
	output logic allow_mmc_eth_config,
	output logic zest_pwr_en,
	output logic [3:0] ext_config,
	output logic [1:0] led_user_mode,
	output logic led1,
	output logic led2
);

	lb_pkg::lb_word_t status_word;
	lb_pkg::lb_word_t ctrl_word;
	lb_pkg::lb_word_t mirror_word;
	marble_regs_pkg::misc_config_t misc_config;

	// ------------------------------------------------------------
	// Bus bundle
	// ------------------------------------------------------------
	lb_if bus ();

	assign bus.addr = addr;
	assign bus.strobe = control_strobe;
	assign bus.rd = control_rd;
	assign bus.wdata = data_out;

	// ------------------------------------------------------------
	// Banks and read combiner
	// ------------------------------------------------------------
	status_bank u_status (
		.clk               (clk),
		.rst_n             (rst_n),
		.bus               (bus.bank_rd),
		.xdomain_fault     (xdomain_fault),
		.tx_mac_done       (tx_mac_done),
		.rx_mac_buf_status (rx_mac_buf_status),
		.status_word       (status_word)
	);

	control_bank u_control (
		.clk           (clk),
		.rst_n         (rst_n),
		.bus           (bus.bank_rw),
		.ctrl_word     (ctrl_word),
		.mirror_word   (mirror_word),
		.rx_mac_hbank  (rx_mac_hbank),
		.misc_config   (misc_config),
		.led_user_mode (led_user_mode),
		.led1          (led1),
		.led2          (led2)
	);

	read_mux u_read_mux (
		.clk         (clk),
		.rst_n       (rst_n),
		.rd_strobe   (control_strobe & control_rd),
		.addr        (addr),
		.status_word (status_word),
		.ctrl_word   (ctrl_word),
		.mirror_word (mirror_word),
		.data_in     (data_in),
		.data_valid  (data_valid)
	);

	// Misc byte fans out to board pins
	assign cfg_d02 = misc_config.cfg_d02;
	assign mmc_int = misc_config.mmc_int;
	assign allow_mmc_eth_config = misc_config.allow_mmc_eth_config;
	assign zest_pwr_en = misc_config.zest_pwr_en;
	assign ext_config = misc_config.ext_config;

endmodule

// File: hw/lb_pkg.sv
// Local bus word, address and region types; region is always the top address byte
`include "marble_cfg.svh"

package lb_pkg;

	// ------------------------------------------------------------
	// Bus words
	// ------------------------------------------------------------
	typedef logic [`LB_AW-1:0] lb_addr_t;
	typedef logic [`LB_DW-1:0] lb_word_t;

	// ------------------------------------------------------------
	// Address regions
	// ------------------------------------------------------------
	// Top byte of the address selects the region
	// Banks region holds status bank at xx0x and control readback at xx1x
	typedef enum logic [7:0] {
		REGION_BANKS  = 8'h00,
		REGION_MIRROR = 8'h05
	} lb_region_e;

	// Returned for anything not mapped
	localparam lb_word_t LB_FILL_WORD = 32'hdeadbeef;

endpackage

// File: hw/led_pwm.sv
// Two-channel LED PWM; duty is 4*df out of 2**LED_CW cycles, so LED_CW must be at least 10
`include "marble_cfg.svh"

module led_pwm (
	input  logic clk,
	input  logic rst_n,
	input  logic [7:0] led1_df,
	input  logic [7:0] led2_df,
	output logic led1,
	output logic led2
);

	logic [`LED_CW-1:0] cnt;
	logic [`LED_CW-1:0] thr1;
	logic [`LED_CW-1:0] thr2;

	// Duty factor scaled by four
	assign thr1 = `LED_CW'({led1_df, 2'b00});
	assign thr2 = `LED_CW'({led2_df, 2'b00});

	// Free-running period counter, outputs registered
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
			led1 <= 1'b0;
			led2 <= 1'b0;
		end else begin
			cnt <= cnt + 1'b1;
			led1 <= cnt < thr1;
			led2 <= cnt < thr2;
		end
	end

endmodule

// File: hw/marble_cfg.svh
// Build constants for the local-bus slave; bus widths are fixed at 24/32 and PWM needs LED_CW >= 10
`ifndef MARBLE_CFG_SVH
`define MARBLE_CFG_SVH

// ------------------------------------------------------------
// Local bus geometry
// ------------------------------------------------------------
`define LB_AW 24
`define LB_DW 32

// Mirror memory depth is 2**MIRROR_AW words
`define MIRROR_AW 5

// ------------------------------------------------------------
// Counter sizes
// ------------------------------------------------------------
// PWM period and uptime prescale, 1024 cycles at 10 bits
`define LED_CW 10
`define FAULT_CW 16
`define UPTIME_W 32

// ------------------------------------------------------------
// Reset defaults of the direct control registers
// ------------------------------------------------------------
`define MISC_CONFIG_DEFAULT 8'h00
`define RX_HBANK_DEFAULT 1'b1

`endif

// File: hw/marble_regs_pkg.sv
// Register map of the slave; slot numbers are shared by control writes and control readback
package marble_regs_pkg;

	// ------------------------------------------------------------
	// Status bank slots, selected by addr[3:0]
	// ------------------------------------------------------------
	// Unlisted slots read as zero
	typedef enum logic [3:0] {
		HELLO0      = 4'd0,
		HELLO1      = 4'd1,
		HELLO2      = 4'd2,
		HELLO3      = 4'd3,
		FAULT_COUNT = 4'd4,
		TX_MAC_DONE = 4'd6,
		RX_MAC_BUF  = 4'd7,
		UPTIME      = 4'd8
	} status_idx_e;

	// ------------------------------------------------------------
	// Direct control registers, selected by addr[4:0]
	// ------------------------------------------------------------
	// Writes land in region 0x05
	// Readback uses the same numbers with addr[4] set in region 0x00
	typedef enum logic [4:0] {
		LED_USER    = 5'd1,
		LED1_DF     = 5'd2,
		LED2_DF     = 5'd3,
		RX_HBANK    = 5'd5,
		MISC_CONFIG = 5'd8
	} ctrl_idx_e;

	// ------------------------------------------------------------
	// Misc configuration byte
	// ------------------------------------------------------------
	// Bit 0 is cfg_d02, top nibble drives ext_config
	typedef struct packed {
		logic [3:0] ext_config;
		logic zest_pwr_en;
		logic allow_mmc_eth_config;
		logic mmc_int;
		logic cfg_d02;
	} misc_config_t;

endpackage

// File: hw/read_mux.sv
// Second read stage; assumes bank words are latched on the same edge the strobe is sampled
`include "marble_cfg.svh"

module read_mux (
	input  logic clk,
	input  logic rst_n,
	input  logic rd_strobe,
	input  lb_pkg::lb_addr_t addr,
	input  lb_pkg::lb_word_t status_word,
	input  lb_pkg::lb_word_t ctrl_word,
	input  lb_pkg::lb_word_t mirror_word,
	output lb_pkg::lb_word_t data_in,
	output logic data_valid
);

	logic rd_r;
	lb_pkg::lb_addr_t addr_r;

	// Line up strobe and address with the bank words
	always_ff @(posedge clk) begin
		if (!rst_n)
			rd_r <= 1'b0;
		else
			rd_r <= rd_strobe;
	end

	always_ff @(posedge clk) begin
		addr_r <= addr;
	end

	// ------------------------------------------------------------
	// Region select
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rd_r) begin
			case (lb_pkg::lb_region_e'(addr_r[`LB_AW-1 -: 8]))
				lb_pkg::REGION_BANKS:
					// Only the first two sixteen-word banks exist
					if (addr_r[7:4] == 4'h0)
						data_in <= status_word;
					else if (addr_r[7:4] == 4'h1)
						data_in <= ctrl_word;
					else
						data_in <= lb_pkg::LB_FILL_WORD;
				lb_pkg::REGION_MIRROR: data_in <= mirror_word;
				default:               data_in <= lb_pkg::LB_FILL_WORD;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			data_valid <= 1'b0;
		else
			data_valid <= rd_r;
	end

	// Every valid pulse belongs to a read two edges back
	a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
		data_valid |-> $past(rd_strobe, 2))
		else $error("data_valid without a read two cycles earlier");

endmodule

// File: hw/status_bank.sv
// Read-only status bank; fault and MAC inputs must already be in the clk domain, uptime wraps
`include "marble_cfg.svh"

module status_bank (
	input  logic clk,
	input  logic rst_n,
	lb_if.bank_rd bus,
	input  logic xdomain_fault,
	input  logic tx_mac_done,
	input  logic [1:0] rx_mac_buf_status,
	output lb_pkg::lb_word_t status_word
);

	logic do_rd;
	logic [`FAULT_CW-1:0] fault_count;
	logic [`LED_CW-1:0] prescale;
	logic [`UPTIME_W-1:0] uptime;
	logic tx_mac_done_r;
	logic [1:0] rx_mac_buf_status_r;

	assign do_rd = bus.strobe & bus.rd;

	// ------------------------------------------------------------
	// Counters
	// ------------------------------------------------------------
	// One count per cycle of fault, bursts expected at startup
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fault_count <= '0;
		end else if (xdomain_fault) begin
			fault_count <= fault_count + 1'b1;
		end
	end

	// Uptime ticks once per prescaler wrap
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			prescale <= '0;
			uptime <= '0;
		end else begin
			prescale <= prescale + 1'b1;
			if (&prescale)
				uptime <= uptime + 1'b1;
		end
	end

	// Register MAC status so all reads come from one clock
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tx_mac_done_r <= 1'b0;
			rx_mac_buf_status_r <= 2'b00;
		end else begin
			tx_mac_done_r <= tx_mac_done;
			rx_mac_buf_status_r <= rx_mac_buf_status;
		end
	end

	// ------------------------------------------------------------
	// First read stage
	// ------------------------------------------------------------
	// Word held until next read, so the mux stage can pick it up
	always_ff @(posedge clk) begin
		if (do_rd) begin
			case (marble_regs_pkg::status_idx_e'(bus.addr[3:0]))
				marble_regs_pkg::HELLO0:      status_word <= "Hell";
				marble_regs_pkg::HELLO1:      status_word <= "o wo";
				marble_regs_pkg::HELLO2:      status_word <= "rld!";
				marble_regs_pkg::HELLO3:      status_word <= "(::)";
				marble_regs_pkg::FAULT_COUNT: status_word <= lb_pkg::lb_word_t'(fault_count);
				marble_regs_pkg::TX_MAC_DONE: status_word <= lb_pkg::lb_word_t'(tx_mac_done_r);
				marble_regs_pkg::RX_MAC_BUF:  status_word <= lb_pkg::lb_word_t'(rx_mac_buf_status_r);
				marble_regs_pkg::UPTIME:      status_word <= lb_pkg::lb_word_t'(uptime);
				default:                      status_word <= '0;
			endcase
		end
	end

	// Fault count only moves forward, or back to zero on wrap
	a_fault_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
		rst_n |=> (fault_count >= $past(fault_count)) || (fault_count == '0))
		else $error("fault counter went backwards");

endmodule

// File: sim.f
+incdir+hw
hw/lb_pkg.sv
hw/marble_regs_pkg.sv
hw/lb_if.sv
hw/led_pwm.sv
hw/status_bank.sv
hw/control_bank.sv
hw/read_mux.sv
hw/lb_marble_slave.sv
tests/tb_lb_marble_slave.sv

// File: tests/marble_cases.mem
// op addr data expect; op 0 write, 1 read, 2 fault pulses, 3 wait, 4 outputs,
// 5 uptime read (expect is least rise), 6 led1 on-cycles, 7 read with no gap
1 000011 0 0        // Reset values of the control slots
1 000015 0 1
1 000018 0 0
4 0 0 100
1 000000 0 48656c6c // Greeting words back to back
7 000001 0 6f20776f
7 000002 0 726c6421
7 000003 0 283a3a29
1 000020 0 deadbeef // Unmapped regions
1 120000 0 deadbeef
1 0000f4 0 deadbeef
0 050007 a5a5a5a5 0 // Mirror aliasing modulo 32
0 05003b 12345678 0
1 050027 0 a5a5a5a5
7 05001b 0 12345678
7 050007 0 a5a5a5a5
0 050008 5d 0       // MISC_CONFIG, LED_USER, RX_HBANK
0 050001 2 0
0 050005 0 0
4 0 0 45d
1 000018 0 5d
2 0 7 0             // Fault counter
1 000004 0 7
5 000008 0 0        // Uptime rises over one prescale period
3 0 480 0
5 000008 0 1
0 050002 40 0       // LED1 duty factors
6 0 0 100
0 050002 ff 0
6 0 0 3fc

// File: tests/tb_lb_marble_slave.sv
// Testbench for the local-bus slave; runs from the project root so the cases file path resolves
`include "marble_cfg.svh"

module tb_lb_marble_slave;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_CASES = 64;
	// Longest case is one PWM window plus its settling cycles
	localparam int CASE_CYCLES = 2 * (2 ** `LED_CW);
	// Slots the cases file does not fill keep this mark
	localparam logic [31:0] END_MARK = 32'hffff_ffff;

	logic clk;
	logic rst_n;
	lb_pkg::lb_addr_t addr;
	logic control_strobe;
	logic control_rd;
	lb_pkg::lb_word_t data_out;
	lb_pkg::lb_word_t data_in;
	logic data_valid;
	logic xdomain_fault;
	logic tx_mac_done;
	logic [1:0] rx_mac_buf_status;
	logic rx_mac_hbank;
	logic cfg_d02;
	logic mmc_int;
	logic allow_mmc_eth_config;
	logic zest_pwr_en;
	logic [3:0] ext_config;
	logic [1:0] led_user_mode;
	logic led1;
	logic led2;

	// Four words per case: op, address, data, expected
	logic [31:0] cases [0:4*MAX_CASES-1];
	logic [31:0] op;
	logic [31:0] c_addr;
	logic [31:0] c_data;
	logic [31:0] c_exp;
	int n_cases;
	int loaded;
	int i;
	int errors;
	int checks;
	int cycle;
	integer seed;
	logic [31:0] last_uptime;

	// Outstanding reads, oldest first
	logic [31:0] exp_q[$];
	int mode_q[$];
	int issue_q[$];

	lb_marble_slave DUT (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Edge count, used to time each read response
	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// ------------------------------------------------------------
	// Checking helpers
	// ------------------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s got %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// Mode 1 is an uptime read, exp is then the least rise since the last one
	task automatic check_read(input logic [31:0] exp, input int mode, input int issued);
		if (cycle != issued + 2) begin
			$display("At %0t ns a read answered %0d cycles after its strobe instead of 2",
				$time, cycle - issued);
			errors++;
		end
		if (mode == 1) begin
			checks++;
			if (data_in < last_uptime + exp) begin
				$display("CHECK FAILED at %0t ns: data_in (uptime) got %h, expected at least %h",
					$time, data_in, last_uptime + exp);
				errors++;
			end
			last_uptime = data_in;
		end else begin
			check_value("data_in", data_in, exp);
		end
	endtask

	// Responses sampled mid-cycle where data_in is stable
	always @(negedge clk) begin
		if (rst_n && data_valid) begin
			if (exp_q.size() == 0) begin
				$display("At %0t ns data_valid rose with no read outstanding", $time);
				errors++;
			end else begin
				check_read(exp_q.pop_front(), mode_q.pop_front(), issue_q.pop_front());
			end
		end
	end

	// ------------------------------------------------------------
	// Bus and pin drivers, all start and end on a falling edge
	// ------------------------------------------------------------
	task automatic issue_read(input logic [31:0] a, input logic [31:0] exp, input int mode);
		addr = a[`LB_AW-1:0];
		control_strobe = 1'b1;
		control_rd = 1'b1;
		exp_q.push_back(exp);
		mode_q.push_back(mode);
		// Cycle in which the strobe is driven
		issue_q.push_back(cycle);
		@(negedge clk);
		control_strobe = 1'b0;
		control_rd = 1'b0;
	endtask

	task automatic issue_write(input logic [31:0] a, input logic [31:0] d);
		addr = a[`LB_AW-1:0];
		data_out = d;
		control_strobe = 1'b1;
		control_rd = 1'b0;
		@(negedge clk);
		control_strobe = 1'b0;
	endtask

	// Single-cycle pulses with a low cycle between them
	task automatic pulse_fault(input int n);
		repeat (n) begin
			xdomain_fault = 1'b1;
			@(negedge clk);
			xdomain_fault = 1'b0;
			@(negedge clk);
		end
	endtask

	// Bits 7:0 misc byte, bit 8 rx_mac_hbank, bits 10:9 led_user_mode
	task automatic check_outputs(input logic [31:0] exp);
		check_value("cfg_d02", cfg_d02, exp[0]);
		check_value("mmc_int", mmc_int, exp[1]);
		check_value("allow_mmc_eth_config", allow_mmc_eth_config, exp[2]);
		check_value("zest_pwr_en", zest_pwr_en, exp[3]);
		check_value("ext_config", ext_config, exp[7:4]);
		check_value("rx_mac_hbank", rx_mac_hbank, exp[8]);
		check_value("led_user_mode", led_user_mode, exp[10:9]);
	endtask

	// Two cycles for a new duty factor to reach the pin
	task automatic count_led1(input logic [31:0] exp);
		int on_cycles;
		on_cycles = 0;
		repeat (2) @(negedge clk);
		repeat (2 ** `LED_CW) begin
			if (led1)
				on_cycles++;
			@(negedge clk);
		end
		check_value("led1 on-cycles", on_cycles, exp);
	endtask

	// Let the last reads come back, a few cycles at most
	task automatic drain_reads();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < 8) begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("At %0t ns %0d reads never got data_valid", $time, exp_q.size());
			errors += exp_q.size();
		end
	endtask

	// ------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------
	initial begin
		seed = 32'h5bb94fe3;
		errors = 0;
		checks = 0;
		last_uptime = '0;
		rst_n = 1'b0;
		addr = '0;
		control_strobe = 1'b0;
		control_rd = 1'b0;
		data_out = '0;
		xdomain_fault = 1'b0;
		tx_mac_done = 1'b0;
		rx_mac_buf_status = 2'b00;
		for (i = 0; i < 4*MAX_CASES; i++)
			cases[i] = END_MARK;
		$readmemh("tests/marble_cases.mem", cases);
		loaded = 0;
		while (loaded < MAX_CASES && cases[4*loaded] != END_MARK)
			loaded++;
		n_cases = loaded;
		if (n_cases == 0) begin
			$display("No cases could be read from tests/marble_cases.mem");
			errors++;
		end
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_value("data_valid", data_valid, 1'b0);
		check_value("led1", led1, 1'b0);
		check_value("led2", led2, 1'b0);
		for (i = 0; i < n_cases; i++) begin
			op = cases[4*i];
			c_addr = cases[4*i+1];
			c_data = cases[4*i+2];
			c_exp = cases[4*i+3];
			// Op 7 follows the previous read with no gap
			if (op != 7)
				repeat ({$random(seed)} % 4) @(negedge clk);
			case (op)
				0: issue_write(c_addr, c_data);
				1, 7: issue_read(c_addr, c_exp, 0);
				2: pulse_fault(c_data);
				3: repeat (c_data) @(negedge clk);
				4: check_outputs(c_exp);
				5: issue_read(c_addr, c_exp, 1);
				6: count_led1(c_exp);
				default: begin
					$display("Case %0d has unknown operation %0h", i, op);
					errors++;
				end
			endcase
		end
		drain_reads();
		// Idle cycles catch a stray data_valid
		repeat (4) @(negedge clk);
		$display("Cases: %0d, checks: %0d, errors: %0d", n_cases, checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Watchdog sized from the case count
	initial begin
		wait (n_cases > 0);
		#((n_cases + 4) * CASE_CYCLES * 8);
		$display("Timeout, the cases did not finish in the allowed time");
		$display("Test failed");
		$finish;
	end

endmodule
